/* hdl/app_if_issue.sv */
`timescale 1ns/1ps

module app_if_issue
(
   input  logic clk,
   input  logic rst,
   input  logic wr_req,
   input  logic rd_req,
   input  logic app_af_afull,
   input  logic app_wdf_afull,
   input  logic line_done,
   output logic accept,
   output logic beat_take,
   output logic app_af_wren,
   output logic app_wdf_wren,
   output logic busy
);

   import mig_line_pkg::*;

   issue_state_e state;
   issue_state_e state_nxt;

   ///////////////////////////////////////////////////////////////////////
   // request intake
   ///////////////////////////////////////////////////////////////////////

   // strobes only count while idle
   // anything arriving later is dropped
   assign accept = (state == ST_IDLE) && (wr_req || rd_req);

   // busy for the whole life of a line
   assign busy = (state != ST_IDLE);

   ///////////////////////////////////////////////////////////////////////
   // FIFO enables
   ///////////////////////////////////////////////////////////////////////

   // command goes out as soon as the address FIFO has room
   assign app_af_wren = ((state == ST_WR_CMD) || (state == ST_RD_CMD))
                        && !app_af_afull;

   // one beat per cycle with room in the write-data FIFO
   assign app_wdf_wren = ((state == ST_WR_BEAT0) || (state == ST_WR_BEAT1))
                         && !app_wdf_afull;

   // splitter steps on exactly the beats that were written
   assign beat_take = app_wdf_wren;

   ///////////////////////////////////////////////////////////////////////
   // next state
   ///////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_nxt = state;
      unique case (state)
         ST_IDLE:
         begin
            // write has priority over read
            if (wr_req)
            begin
               state_nxt = ST_WR_CMD;
            end
            else if (rd_req)
            begin
               state_nxt = ST_RD_CMD;
            end
         end
         ST_WR_CMD:
         begin
            if (app_af_wren)
            begin
               state_nxt = ST_WR_BEAT0;
            end
         end
         ST_WR_BEAT0:
         begin
            if (app_wdf_wren)
            begin
               state_nxt = ST_WR_BEAT1;
            end
         end
         ST_WR_BEAT1:
         begin
            // last beat closes the write
            if (app_wdf_wren)
            begin
               state_nxt = ST_IDLE;
            end
         end
         ST_RD_CMD:
         begin
            if (app_af_wren)
            begin
               state_nxt = ST_RD_WAIT;
            end
         end
         ST_RD_WAIT:
         begin
            // gatherer reports the full line
            if (line_done)
            begin
               state_nxt = ST_IDLE;
            end
         end
         default:
         begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= ST_IDLE;
      end
      else
      begin
         state <= state_nxt;
      end
   end

endmodule

/* hdl/line_addr_map.sv */
`timescale 1ns/1ps

module line_addr_map #(
   parameter int BANK_WIDTH = 2,
   parameter int ROW_WIDTH  = 13,
   parameter int COL_WIDTH  = 10
)
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         accept,
   input  logic                         wr_req,
   input  logic [BANK_WIDTH+ROW_WIDTH+COL_WIDTH
                 -mig_line_pkg::COLS_PER_LINE_LOG2-1:0] line_idx,
   output logic [BANK_WIDTH+ROW_WIDTH+COL_WIDTH-1:0] app_af_addr,
   output mig_line_pkg::app_cmd_e       app_af_cmd
);

   import mig_line_pkg::*;

   // index bits that land in the column field
   localparam int COL_IDX_WIDTH = COL_WIDTH - COLS_PER_LINE_LOG2;

   ///////////////////////////////////////////////////////////////////////
   // index split
   ///////////////////////////////////////////////////////////////////////

   logic [BANK_WIDTH-1:0] bank;
   logic [ROW_WIDTH-1:0]  row;
   logic [COL_WIDTH-1:0]  col;

   // low index bits pick the line within a row
   // column gets two zero bits below, one line spans four columns
   assign col = {line_idx[COL_IDX_WIDTH-1:0], {COLS_PER_LINE_LOG2{1'b0}}};

   // row sits directly above the column bits
   assign row = line_idx[COL_IDX_WIDTH +: ROW_WIDTH];

   // bank takes the top of the index
   assign bank = line_idx[COL_IDX_WIDTH+ROW_WIDTH +: BANK_WIDTH];

   ///////////////////////////////////////////////////////////////////////
   // request latch
   ///////////////////////////////////////////////////////////////////////

   // command is control state, back to write after reset
   // write wins when both strobes come together
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         app_af_cmd <= CMD_WRITE;
      end
      else if (accept)
      begin
         app_af_cmd <= wr_req ? CMD_WRITE : CMD_READ;
      end
   end

   // packed address, bank then row then column
   // stays put until the next accepted request
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         app_af_addr <= {bank, row, col};
      end
   end

endmodule

/* hdl/line_beat_split.sv */
`timescale 1ns/1ps

module line_beat_split #(
   parameter int APPDATA_WIDTH = 128
)
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     accept,
   input  logic [mig_line_pkg::BEATS_PER_LINE*APPDATA_WIDTH-1:0] wr_line,
   input  logic                     beat_take,
   output logic [APPDATA_WIDTH-1:0] app_wdf_data
);

   ///////////////////////////////////////////////////////////////////////
   // line storage
   ///////////////////////////////////////////////////////////////////////

   // held halves of the accepted line
   logic [APPDATA_WIDTH-1:0] line_lo;
   logic [APPDATA_WIDTH-1:0] line_hi;

   // beat pointer, 0 = low half on the bus
   logic                     beat_sel;

   // payload only, loaded once per accept
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         line_lo <= wr_line[APPDATA_WIDTH-1:0];
         line_hi <= wr_line[2*APPDATA_WIDTH-1:APPDATA_WIDTH];
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // beat pointer
   ///////////////////////////////////////////////////////////////////////

   // a new line always starts on the low half
   // each taken beat moves to the other half
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         beat_sel <= 1'b0;
      end
      else if (accept)
      begin
         beat_sel <= 1'b0;
      end
      else if (beat_take)
      begin
         beat_sel <= ~beat_sel;
      end
   end

   // current beat straight onto the write-data FIFO
   assign app_wdf_data = beat_sel ? line_hi : line_lo;

endmodule

/* hdl/mig_line_pkg.sv */
package mig_line_pkg;

   ///////////////////////////////////////////////////////////////////////
   // controller commands
   ///////////////////////////////////////////////////////////////////////

   // encodings of the app_af_cmd field on the address FIFO
   // only write and read are used by the line port
   typedef enum logic [2:0]
   {
      CMD_WRITE = 3'b000,
      CMD_READ  = 3'b001
   } app_cmd_e;

   ///////////////////////////////////////////////////////////////////////
   // issue engine states
   ///////////////////////////////////////////////////////////////////////

   // write path goes through three states, read path through two
   typedef enum logic [2:0]
   {
      ST_IDLE     = 3'd0,
      ST_WR_CMD   = 3'd1,
      ST_WR_BEAT0 = 3'd2,
      ST_WR_BEAT1 = 3'd3,
      ST_RD_CMD   = 3'd4,
      ST_RD_WAIT  = 3'd5
   } issue_state_e;

   ///////////////////////////////////////////////////////////////////////
   // line geometry
   ///////////////////////////////////////////////////////////////////////

   // data beats per cache line
   localparam int BEATS_PER_LINE = 2;

   // four column addresses per line, as a shift
   localparam int COLS_PER_LINE_LOG2 = 2;

endpackage

/* hdl/mig_line_port.sv */
`timescale 1ns/1ps

module mig_line_port #(
   parameter int  APPDATA_WIDTH  = 128,
   parameter int  BANK_WIDTH     = 2,
   parameter int  ROW_WIDTH      = 13,
   parameter int  COL_WIDTH      = 10,
   localparam int ADDR_WIDTH     = BANK_WIDTH + ROW_WIDTH + COL_WIDTH,
   localparam int LINE_IDX_WIDTH = ADDR_WIDTH - mig_line_pkg::COLS_PER_LINE_LOG2
)
(
   input  logic                        clk,
   input  logic                        rst,
   // client side
   input  logic                        wr_req,
   input  logic                        rd_req,
   input  logic [LINE_IDX_WIDTH-1:0]   line_idx,
   input  logic [mig_line_pkg::BEATS_PER_LINE*APPDATA_WIDTH-1:0] wr_line,
   output logic                        busy,
   output logic [mig_line_pkg::BEATS_PER_LINE*APPDATA_WIDTH-1:0] rd_line,
   output logic                        rd_line_valid,
   // controller address FIFO
   output logic                        app_af_wren,
   output logic [ADDR_WIDTH-1:0]       app_af_addr,
   output mig_line_pkg::app_cmd_e      app_af_cmd,
   input  logic                        app_af_afull,
   // controller write-data FIFO
   output logic                        app_wdf_wren,
   output logic [APPDATA_WIDTH-1:0]    app_wdf_data,
   output logic [APPDATA_WIDTH/8-1:0]  app_wdf_mask_data,
   input  logic                        app_wdf_afull,
   // controller read return
   input  logic                        rd_data_valid,
   input  logic [APPDATA_WIDTH-1:0]    rd_data_fifo_out
);

   // engine to datapath strobes
   logic accept;
   logic beat_take;

   // no byte masking, every byte written
   assign app_wdf_mask_data = '0;

   ///////////////////////////////////////////////////////////////////////
   // datapath
   ///////////////////////////////////////////////////////////////////////

   line_addr_map #(
      .BANK_WIDTH (BANK_WIDTH),
      .ROW_WIDTH  (ROW_WIDTH),
      .COL_WIDTH  (COL_WIDTH)
   ) u_line_addr_map (
      .clk         (clk),
      .rst         (rst),
      .accept      (accept),
      .wr_req      (wr_req),
      .line_idx    (line_idx),
      .app_af_addr (app_af_addr),
      .app_af_cmd  (app_af_cmd)
   );

   line_beat_split #(
      .APPDATA_WIDTH (APPDATA_WIDTH)
   ) u_line_beat_split (
      .clk          (clk),
      .rst          (rst),
      .accept       (accept),
      .wr_line      (wr_line),
      .beat_take    (beat_take),
      .app_wdf_data (app_wdf_data)
   );

   ///////////////////////////////////////////////////////////////////////
   // control and read return
   ///////////////////////////////////////////////////////////////////////

   // read ends when the gathered line pulses out
   app_if_issue u_app_if_issue (
      .clk           (clk),
      .rst           (rst),
      .wr_req        (wr_req),
      .rd_req        (rd_req),
      .app_af_afull  (app_af_afull),
      .app_wdf_afull (app_wdf_afull),
      .line_done     (rd_line_valid),
      .accept        (accept),
      .beat_take     (beat_take),
      .app_af_wren   (app_af_wren),
      .app_wdf_wren  (app_wdf_wren),
      .busy          (busy)
   );

   rd_line_gather #(
      .APPDATA_WIDTH (APPDATA_WIDTH)
   ) u_rd_line_gather (
      .clk              (clk),
      .rst              (rst),
      .rd_data_valid    (rd_data_valid),
      .rd_data_fifo_out (rd_data_fifo_out),
      .rd_line          (rd_line),
      .rd_line_valid    (rd_line_valid)
   );

endmodule

/* hdl/rd_line_gather.sv */
`timescale 1ns/1ps

module rd_line_gather #(
   parameter int APPDATA_WIDTH = 128
)
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     rd_data_valid,
   input  logic [APPDATA_WIDTH-1:0] rd_data_fifo_out,
   output logic [mig_line_pkg::BEATS_PER_LINE*APPDATA_WIDTH-1:0] rd_line,
   output logic                     rd_line_valid
);

   ///////////////////////////////////////////////////////////////////////
   // beat tracking
   ///////////////////////////////////////////////////////////////////////

   // set once the low half has arrived
   logic hi_beat;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         hi_beat       <= 1'b0;
         rd_line_valid <= 1'b0;
      end
      else
      begin
         // single-cycle pulse after the second beat
         rd_line_valid <= rd_data_valid && hi_beat;
         if (rd_data_valid)
         begin
            hi_beat <= ~hi_beat;
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // line assembly
   ///////////////////////////////////////////////////////////////////////

   // first beat low half, second beat high half
   always_ff @(posedge clk)
   begin
      if (rd_data_valid)
      begin
         if (hi_beat)
         begin
            rd_line[2*APPDATA_WIDTH-1:APPDATA_WIDTH] <= rd_data_fifo_out;
         end
         else
         begin
            rd_line[APPDATA_WIDTH-1:0] <= rd_data_fifo_out;
         end
      end
   end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mig_line_port -f tb.f -o sim

out=$(./obj_dir/sim) || true
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
   exit 0
else
   exit 1
fi

/* tb.f */
hdl/mig_line_pkg.sv
hdl/line_addr_map.sv
hdl/line_beat_split.sv
hdl/app_if_issue.sv
hdl/rd_line_gather.sv
hdl/mig_line_port.sv
verif/mig_app_model.sv
verif/mig_line_port_sva.sv
verif/tb_mig_line_port.sv

/* verif/mig_app_model.sv */
`timescale 1ns/1ps

module mig_app_model #(
   parameter int APPDATA_WIDTH = 128,
   parameter int ADDR_WIDTH    = 25
)
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     app_af_wren,
   input  logic [ADDR_WIDTH-1:0]    app_af_addr,
   input  mig_line_pkg::app_cmd_e   app_af_cmd,
   input  logic                     app_wdf_wren,
   input  logic [APPDATA_WIDTH-1:0] app_wdf_data,
   output logic                     app_af_afull,
   output logic                     app_wdf_afull,
   output logic                     rd_data_valid,
   output logic [APPDATA_WIDTH-1:0] rd_data_fifo_out,
   output int                       wr_cmds,
   output int                       rd_cmds,
   output int                       wr_beats
);

   import mig_line_pkg::*;

   // DRAM contents, one entry per 128-bit beat
   logic [APPDATA_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];

   logic [31:0]           rnd;
   logic [ADDR_WIDTH-1:0] wr_addr;
   logic [ADDR_WIDTH-1:0] rd_addr;
   int                    wr_beat;
   int                    rd_beat;
   int                    rd_delay;
   bit                    rd_pend;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // unwritten locations return a pattern of their address
   function automatic logic [APPDATA_WIDTH-1:0] fetch(input logic [ADDR_WIDTH-1:0] a);
      if (mem.exists(a))
      begin
         return mem[a];
      end
      return {(APPDATA_WIDTH/32){32'(a) ^ 32'hc3c3_0000}};
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // controller behaviour
   ///////////////////////////////////////////////////////////////////////

   initial
   begin
      app_af_afull     = 1'b0;
      app_wdf_afull    = 1'b0;
      rd_data_valid    = 1'b0;
      rd_data_fifo_out = '0;
      wr_cmds          = 0;
      rd_cmds          = 0;
      wr_beats         = 0;
      wr_beat          = 0;
      rd_beat          = 0;
      rd_delay         = 0;
      rd_pend          = 1'b0;
      wr_addr          = '0;
      rd_addr          = '0;
      rnd              = 32'h73b2_6cf8;
      forever
      begin
         @(posedge clk);
         // FIFO transfers happen on the edge
         if (!rst && app_af_wren)
         begin
            if (app_af_cmd == CMD_WRITE)
            begin
               wr_addr = app_af_addr;
               wr_beat = 0;
               wr_cmds++;
            end
            else
            begin
               // read data comes back after a random wait
               rd_addr  = app_af_addr;
               rd_beat  = 0;
               rd_delay = 32'(rnd[6:4]);
               rd_pend  = 1'b1;
               rd_cmds++;
            end
         end
         if (!rst && app_wdf_wren)
         begin
            // beat n lands two columns above beat n-1
            mem[wr_addr + ADDR_WIDTH'(2 * wr_beat)] = app_wdf_data;
            wr_beat++;
            wr_beats++;
         end
         #2;
         // stall each FIFO about a quarter of the time
         rnd           = xorshift(rnd);
         app_af_afull  = rnd[0] & rnd[1];
         app_wdf_afull = rnd[2] & rnd[3];
         rd_data_valid = 1'b0;
         if (rd_pend && rd_delay > 0)
         begin
            rd_delay--;
         end
         else if (rd_pend)
         begin
            // two back to back beats, low column first
            rd_data_valid    = 1'b1;
            rd_data_fifo_out = fetch(rd_addr + ADDR_WIDTH'(2 * rd_beat));
            rd_beat++;
            rd_pend = (rd_beat < BEATS_PER_LINE);
         end
      end
   end

endmodule

/* verif/mig_line_port_sva.sv */
`timescale 1ns/1ps

module mig_line_port_sva
(
   input logic                         clk,
   input logic                         rst,
   input logic                         app_af_wren,
   input logic                         app_wdf_wren,
   input logic                         app_wdf_afull,
   input logic                         busy,
   input mig_line_pkg::issue_state_e   state
);

   import mig_line_pkg::*;

   // data beats still owed by the last write command
   logic [1:0] beats_owed;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         beats_owed <= '0;
      end
      else if (app_af_wren && state == ST_WR_CMD)
      begin
         beats_owed <= 2'(BEATS_PER_LINE);
      end
      else if (app_wdf_wren)
      begin
         beats_owed <= beats_owed - 2'd1;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // reset and back-pressure
   ///////////////////////////////////////////////////////////////////////

   reset_idle: assert property (@(posedge clk)
      rst |=> (!busy && !app_af_wren && !app_wdf_wren))
      else $error("issue engine not idle after reset");

   // stalled write-data FIFO keeps the owed beats
   wdf_stall: assert property (@(posedge clk) disable iff (rst)
      (app_wdf_afull && beats_owed != 0) |=> beats_owed == $past(beats_owed))
      else $error("write beat taken while write-data FIFO almost full");

   ///////////////////////////////////////////////////////////////////////
   // write ordering
   ///////////////////////////////////////////////////////////////////////

   // next command only once both beats of a write are out
   cmd_after_beats: assert property (@(posedge clk) disable iff (rst)
      app_af_wren |-> beats_owed == 0)
      else $error("command issued with write beats still owed");

   beat_after_cmd: assert property (@(posedge clk) disable iff (rst)
      app_wdf_wren |-> beats_owed != 0)
      else $error("write beat issued without a write command");

   // a line ends only after all its beats
   end_after_beats: assert property (@(posedge clk) disable iff (rst)
      $fell(busy) |-> beats_owed == 0)
      else $error("busy dropped with write beats still owed");

endmodule

bind app_if_issue mig_line_port_sva u_mig_line_port_sva (
   .clk           (clk),
   .rst           (rst),
   .app_af_wren   (app_af_wren),
   .app_wdf_wren  (app_wdf_wren),
   .app_wdf_afull (app_wdf_afull),
   .busy          (busy),
   .state         (state)
);

/* verif/tb_mig_line_port.sv */
`timescale 1ns/1ps

module tb_mig_line_port;

   import mig_line_pkg::*;

   localparam int DATA_W = 128;
   localparam int BANK_W = 2;
   localparam int ROW_W  = 13;
   localparam int COL_W  = 10;
   localparam int ADDR_W = BANK_W + ROW_W + COL_W;
   localparam int IDX_W  = ADDR_W - COLS_PER_LINE_LOG2;
   localparam int LINE_W = BEATS_PER_LINE * DATA_W;

   // writes wrap around the index pool so some lines get overwritten
   localparam int POOL        = 12;
   localparam int NUM_WRITES  = 16;
   localparam int NUM_NOISY   = 4;
   localparam int NUM_REQ     = NUM_WRITES + POOL + 2 * NUM_NOISY;
   localparam int CYCLE_LIMIT = 60 * NUM_REQ + 20;

   logic clk;
   logic rst;
   logic wr_req;
   logic rd_req;
   logic [IDX_W-1:0]    line_idx;
   logic [LINE_W-1:0]   wr_line;
   logic                busy;
   logic [LINE_W-1:0]   rd_line;
   logic                rd_line_valid;
   logic                app_af_wren;
   logic [ADDR_W-1:0]   app_af_addr;
   app_cmd_e            app_af_cmd;
   logic                app_af_afull;
   logic                app_wdf_wren;
   logic [DATA_W-1:0]   app_wdf_data;
   logic [DATA_W/8-1:0] app_wdf_mask_data;
   logic                app_wdf_afull;
   logic                rd_data_valid;
   logic [DATA_W-1:0]   rd_data_fifo_out;
   int                  wr_cmds;
   int                  rd_cmds;
   int                  wr_beats;

   // scoreboard state
   logic [31:0]       rnd = 32'h73b2_6cf8;
   int                errors = 0;
   int                err_mark = 0;
   int                tests_run = 0;
   int                tests_failed = 0;
   int                cycles = 0;
   int                beat_no = 0;
   int                lines_seen = 0;
   int                wr_accepted = 0;
   int                rd_accepted = 0;
   logic [IDX_W-1:0]  exp_idx = '0;
   app_cmd_e          exp_cmd = CMD_WRITE;
   logic [LINE_W-1:0] exp_line = '0;
   logic [LINE_W-1:0] exp_rd = '0;
   logic [LINE_W-1:0] exp_mem [logic [IDX_W-1:0]];
   logic [IDX_W-1:0]  pool [POOL];

   mig_line_port #(
      .APPDATA_WIDTH (DATA_W),
      .BANK_WIDTH    (BANK_W),
      .ROW_WIDTH     (ROW_W),
      .COL_WIDTH     (COL_W)
   ) u_mig_line_port (
      .clk (clk), .rst (rst),
      .wr_req (wr_req), .rd_req (rd_req), .line_idx (line_idx), .wr_line (wr_line),
      .busy (busy), .rd_line (rd_line), .rd_line_valid (rd_line_valid),
      .app_af_wren (app_af_wren), .app_af_addr (app_af_addr), .app_af_cmd (app_af_cmd),
      .app_af_afull (app_af_afull), .app_wdf_wren (app_wdf_wren),
      .app_wdf_data (app_wdf_data), .app_wdf_mask_data (app_wdf_mask_data),
      .app_wdf_afull (app_wdf_afull), .rd_data_valid (rd_data_valid),
      .rd_data_fifo_out (rd_data_fifo_out)
   );

   mig_app_model #(
      .APPDATA_WIDTH (DATA_W),
      .ADDR_WIDTH    (ADDR_W)
   ) u_mig_app_model (
      .clk (clk), .rst (rst),
      .app_af_wren (app_af_wren), .app_af_addr (app_af_addr), .app_af_cmd (app_af_cmd),
      .app_wdf_wren (app_wdf_wren), .app_wdf_data (app_wdf_data),
      .app_af_afull (app_af_afull), .app_wdf_afull (app_wdf_afull),
      .rd_data_valid (rd_data_valid), .rd_data_fifo_out (rd_data_fifo_out),
      .wr_cmds (wr_cmds), .rd_cmds (rd_cmds), .wr_beats (wr_beats)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ///////////////////////////////////////////////////////////////////////
   // helpers
   ///////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rnd = xorshift(rnd);
      return rnd;
   endfunction

   function automatic logic [LINE_W-1:0] random_line();
      logic [LINE_W-1:0] l;
      for (int i = 0; i < LINE_W / 32; i++)
      begin
         l[32*i +: 32] = next_rand();
      end
      return l;
   endfunction

   // four columns per line, row above column, bank on top
   function automatic logic [ADDR_W-1:0] addr_of(input logic [IDX_W-1:0] idx);
      int unsigned n;
      int unsigned lines_per_row;
      int unsigned col;
      int unsigned row;
      int unsigned bank;
      n             = 32'(idx);
      lines_per_row = 1 << (COL_W - COLS_PER_LINE_LOG2);
      col           = (n % lines_per_row) * 4;
      row           = (n / lines_per_row) % (1 << ROW_W);
      bank          = n / (lines_per_row << ROW_W);
      return ADDR_W'((bank << (ROW_W + COL_W)) | (row << COL_W) | col);
   endfunction

   function automatic logic [DATA_W-1:0] expected_beat(input int n);
      return (n == 0) ? exp_line[DATA_W-1:0] : exp_line[LINE_W-1:DATA_W];
   endfunction

   task automatic report_value(input string name, input logic [LINE_W-1:0] exp_v,
                               input logic [LINE_W-1:0] got_v);
      $display("FAIL t=%0t %s exp=%0h got=%0h", $time, name, exp_v, got_v);
      errors++;
   endtask

   task automatic report_error(input string what);
      $display("error at t=%0t: %s", $time, what);
      errors++;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == err_mark)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: %0d check(s) failed", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   // one request and then wait for busy to drop
   // noisy mode pulses junk strobes while busy
   task automatic issue_request(input bit is_wr, input logic [IDX_W-1:0] idx, input bit noisy);
      logic [LINE_W-1:0] line;
      logic [31:0]       r;
      line     = random_line();
      exp_idx  = idx;
      exp_cmd  = is_wr ? CMD_WRITE : CMD_READ;
      exp_line = line;
      beat_no  = 0;
      if (is_wr)
      begin
         exp_mem[idx] = line;
         wr_accepted++;
      end
      else
      begin
         exp_rd = exp_mem[idx];
         rd_accepted++;
      end
      wr_req   = is_wr;
      rd_req   = !is_wr;
      line_idx = idx;
      wr_line  = line;
      @(posedge clk);
      #2;
      wr_req = 1'b0;
      rd_req = 1'b0;
      while (busy)
      begin
         if (noisy)
         begin
            r        = next_rand();
            wr_req   = r[0];
            rd_req   = r[1];
            line_idx = r[IDX_W+1:2];
            wr_line  = ~line;
         end
         @(posedge clk);
         #2;
         wr_req = 1'b0;
         rd_req = 1'b0;
      end
   endtask

   task automatic check_reset_state();
      repeat (4)
      begin
         @(posedge clk);
         #2;
         assert (!busy && !app_af_wren && !app_wdf_wren && !rd_line_valid
                 && app_af_cmd == CMD_WRITE)
            else report_error("outputs not idle after reset");
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // checking on every edge
   ///////////////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (!rst)
      begin
         assert (app_wdf_mask_data == '0)
            else report_value("app_wdf_mask_data", '0, LINE_W'(app_wdf_mask_data));
         assert (!(app_af_wren && app_af_afull))
            else report_error("address FIFO written while almost full");
         assert (!(app_wdf_wren && app_wdf_afull))
            else report_error("write-data FIFO written while almost full");
         if (app_af_wren)
         begin
            assert (app_af_addr == addr_of(exp_idx))
               else report_value("app_af_addr", LINE_W'(addr_of(exp_idx)), LINE_W'(app_af_addr));
            assert (app_af_cmd == exp_cmd)
               else report_value("app_af_cmd", LINE_W'(exp_cmd), LINE_W'(app_af_cmd));
         end
         if (app_wdf_wren)
         begin
            // low half first and never more than two beats
            assert (exp_cmd == CMD_WRITE && beat_no < BEATS_PER_LINE)
               else report_error("write beat issued outside a write line");
            assert (app_wdf_data == expected_beat(beat_no))
               else report_value("app_wdf_data", LINE_W'(expected_beat(beat_no)),
                                 LINE_W'(app_wdf_data));
            beat_no++;
         end
         if (rd_line_valid)
         begin
            assert (exp_cmd == CMD_READ)
               else report_error("read line returned without a read request");
            assert (rd_line == exp_rd)
               else report_value("rd_line", exp_rd, rd_line);
            lines_seen++;
         end
      end
   end

   // run limit
   always @(posedge clk)
   begin
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Regression failed");
         $finish;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // test sequence
   ///////////////////////////////////////////////////////////////////////

   initial
   begin
      rst      = 1'b1;
      wr_req   = 1'b0;
      rd_req   = 1'b0;
      line_idx = '0;
      wr_line  = '0;
      repeat (10) @(posedge clk);
      #2;
      rst = 1'b0;
      check_reset_state();
      finish_test("reset_state");

      for (int i = 0; i < POOL; i++)
      begin
         pool[i] = IDX_W'(random_line());
      end
      for (int i = 0; i < NUM_WRITES; i++)
      begin
         issue_request(1'b1, pool[i % POOL], 1'b0);
      end
      finish_test("write_lines");

      // every pool entry holds its last written line
      for (int i = 0; i < POOL; i++)
      begin
         issue_request(1'b0, pool[i], 1'b0);
      end
      finish_test("read_back");

      for (int i = 0; i < NUM_NOISY; i++)
      begin
         issue_request(1'b1, pool[i], 1'b1);
         issue_request(1'b0, pool[i], 1'b1);
      end
      finish_test("dropped_requests");

      // one command per accepted request and two beats per write
      repeat (2) @(posedge clk);
      assert (wr_cmds == wr_accepted)
         else report_value("wr_cmds", LINE_W'(wr_accepted), LINE_W'(wr_cmds));
      assert (rd_cmds == rd_accepted)
         else report_value("rd_cmds", LINE_W'(rd_accepted), LINE_W'(rd_cmds));
      assert (wr_beats == BEATS_PER_LINE * wr_accepted)
         else report_value("wr_beats", LINE_W'(BEATS_PER_LINE * wr_accepted), LINE_W'(wr_beats));
      assert (lines_seen == rd_accepted)
         else report_value("rd_line_valid count", LINE_W'(rd_accepted), LINE_W'(lines_seen));
      finish_test("request_counts");

      $display("tests run %0d, tests failed %0d, checks failed %0d",
               tests_run, tests_failed, errors);
      if (errors == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
